/* include/pcs_cfg.svh */
// Fabric PCS configuration
`ifndef PCS_CFG_SVH
`define PCS_CFG_SVH

// user bytes taken per transmit strobe
`define PCS_DWORD_BYTES 4

// bytes carried by one line cycle
`define PCS_WORD_BYTES 2

// width of one 8b/10b symbol
`define PCS_SYMBOL_BITS 10

// K28.5 comma, both polarities, bit a in the msb
`define PCS_K28_5_RDN 10'b0011111010
`define PCS_K28_5_RDP 10'b1100000101

// idle word is K28.5 in the low byte, D21.5 in the high byte
`define PCS_IDLE_DATA 16'hB5BC
`define PCS_IDLE_ISK 2'b01

`endif

/* source/pcs_pkg.sv */
// Fabric PCS shared types
`default_nettype none

`include "pcs_cfg.svh"

package pcs_pkg;

    // user word as presented on each transmit strobe
    typedef struct packed {
        logic [`PCS_DWORD_BYTES-1:0]   charisk;
        logic [`PCS_DWORD_BYTES*8-1:0] data;
    } tx_dword_t;

    // one line cycle worth of bytes ahead of the encoder
    typedef struct packed {
        logic [`PCS_WORD_BYTES-1:0]   charisk;
        logic [`PCS_WORD_BYTES*8-1:0] data;
    } tx_word_t;

    // two symbols per line cycle
    // sym_lo goes out first, msb of each symbol first
    typedef struct packed {
        logic [`PCS_SYMBOL_BITS-1:0] sym_hi;
        logic [`PCS_SYMBOL_BITS-1:0] sym_lo;
    } line_word_t;

    // decoded receive word with per-byte status
    typedef struct packed {
        logic [`PCS_WORD_BYTES-1:0]   disperr;
        logic [`PCS_WORD_BYTES-1:0]   notintable;
        logic [`PCS_WORD_BYTES-1:0]   charisk;
        logic [`PCS_WORD_BYTES*8-1:0] data;
    } rx_word_t;

endpackage

`default_nettype wire

/* source/tx_gearbox.sv */
// Transmit gearbox
`default_nettype none
`timescale 1ns/100ps

`include "pcs_cfg.svh"

module tx_gearbox
    import pcs_pkg::*;
(
    input  logic      txusrclk,
    input  logic      rst,
    input  logic      tx_strobe,
    input  tx_dword_t tx_dword,
    output tx_word_t  enc_word
);

    localparam int       WB        = `PCS_WORD_BYTES;
    localparam tx_word_t IDLE_WORD = '{charisk: `PCS_IDLE_ISK, data: `PCS_IDLE_DATA};

    tx_dword_t hold;
    logic      lo_pending;
    logic      hi_pending;
    logic      accept;

    // a strobe right behind an accepted one is dropped
    assign accept = tx_strobe & ~lo_pending;

    always_ff @(posedge txusrclk) begin
        if (accept) begin
            hold <= tx_dword;
        end
    end

    always_ff @(posedge txusrclk) begin
        if (rst) begin
            lo_pending <= 1'b0;
            hi_pending <= 1'b0;
            enc_word   <= IDLE_WORD;
        end else begin
            lo_pending <= accept;
            hi_pending <= lo_pending;
            if (lo_pending) begin
                enc_word.data    <= hold.data[WB*8-1:0];
                enc_word.charisk <= hold.charisk[WB-1:0];
            end else if (hi_pending) begin
                enc_word.data    <= hold.data[2*WB*8-1:WB*8];
                enc_word.charisk <= hold.charisk[2*WB-1:WB];
            end else begin
                // keep the line busy with commas while nothing is queued
                enc_word <= IDLE_WORD;
            end
        end
    end

endmodule

`default_nettype wire

/* source/enc_8b10b.sv */
// Two-byte 8b/10b encoder
`default_nettype none
`timescale 1ns/100ps

module enc_8b10b
    import pcs_pkg::*;
(
    input  logic       txusrclk,
    input  logic       rst,
    input  tx_word_t   enc_word,
    output line_word_t line_tx
);

    // running disparity, 0 is negative
    logic        rd;
    logic [10:0] lo_code;
    logic [10:0] hi_code;

    // result is {ending rd, abcdei, fghj}
    function automatic logic [10:0] encode_byte(
        input logic [7:0] d,
        input logic       k,
        input logic       rd_in
    );
        logic [4:0] x;
        logic [2:0] y;
        logic [5:0] c6;
        logic [3:0] c4;
        logic       rd_mid;
        logic       rd_end;
        logic       alt;
        logic       dd;

        x = d[4:0];
        y = d[7:5];

        // 5b/6b, values for negative running disparity
        case (x)
            5'd0:    c6 = 6'b100111;
            5'd1:    c6 = 6'b011101;
            5'd2:    c6 = 6'b101101;
            5'd3:    c6 = 6'b110001;
            5'd4:    c6 = 6'b110101;
            5'd5:    c6 = 6'b101001;
            5'd6:    c6 = 6'b011001;
            5'd7:    c6 = 6'b111000;
            5'd8:    c6 = 6'b111001;
            5'd9:    c6 = 6'b100101;
            5'd10:   c6 = 6'b010101;
            5'd11:   c6 = 6'b110100;
            5'd12:   c6 = 6'b001101;
            5'd13:   c6 = 6'b101100;
            5'd14:   c6 = 6'b011100;
            5'd15:   c6 = 6'b010111;
            5'd16:   c6 = 6'b011011;
            5'd17:   c6 = 6'b100011;
            5'd18:   c6 = 6'b010011;
            5'd19:   c6 = 6'b110010;
            5'd20:   c6 = 6'b001011;
            5'd21:   c6 = 6'b101010;
            5'd22:   c6 = 6'b011010;
            5'd23:   c6 = 6'b111010;
            5'd24:   c6 = 6'b110011;
            5'd25:   c6 = 6'b100110;
            5'd26:   c6 = 6'b010110;
            5'd27:   c6 = 6'b110110;
            5'd28:   c6 = 6'b001110;
            5'd29:   c6 = 6'b101110;
            5'd30:   c6 = 6'b011110;
            default: c6 = 6'b101011;
        endcase
        if (k && x == 5'd28) begin
            c6 = 6'b001111;
        end
        // unbalanced codes and D.7 flip under positive disparity
        if (rd_in && ($countones(c6) != 3 || x == 5'd7)) begin
            c6 = ~c6;
        end
        rd_mid = ($countones(c6) == 3) ? rd_in : ~rd_in;

        // 3b/4b, negative column
        case (y)
            3'd0:    c4 = 4'b1011;
            3'd1:    c4 = 4'b1001;
            3'd2:    c4 = 4'b0101;
            3'd3:    c4 = 4'b1100;
            3'd4:    c4 = 4'b1101;
            3'd5:    c4 = 4'b1010;
            3'd6:    c4 = 4'b0110;
            default: c4 = 4'b1110;
        endcase

        // alternate x.7 avoids a run of five, always used for K codes
        alt = (y == 3'd7) &&
              (k ||
               (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
               (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
        if (alt) begin
            c4 = 4'b0111;
        end

        // K28 swaps the columns of the balanced 4b codes
        dd = (y == 3'd0 || y == 3'd3 || y == 3'd4 || y == 3'd7);
        if (dd ? rd_mid : (k && !rd_mid)) begin
            c4 = ~c4;
        end
        rd_end = ($countones(c4) == 2) ? rd_mid : ~rd_mid;

        return {rd_end, c6, c4};
    endfunction

    // low byte first, its ending disparity feeds the high byte
    assign lo_code = encode_byte(enc_word.data[7:0], enc_word.charisk[0], rd);
    assign hi_code = encode_byte(enc_word.data[15:8], enc_word.charisk[1], lo_code[10]);

    always_ff @(posedge txusrclk) begin
        line_tx.sym_lo <= lo_code[9:0];
        line_tx.sym_hi <= hi_code[9:0];
        if (rst) begin
            rd <= 1'b0;
        end else begin
            rd <= hi_code[10];
        end
    end

endmodule

`default_nettype wire

/* source/comma_align.sv */
// Receive comma aligner
`default_nettype none
`timescale 1ns/100ps

`include "pcs_cfg.svh"

module comma_align
    import pcs_pkg::*;
(
    input  logic       txusrclk,
    input  logic       rst,
    input  line_word_t line_rx,
    output line_word_t aligned_word,
    output logic       rx_aligned,
    output logic       rx_realign
);

    localparam int SYM = `PCS_SYMBOL_BITS;
    localparam int LW  = 2 * SYM;
    localparam int OW  = $clog2(LW);

    typedef enum logic [1:0] {
        ST_NONALIGNED,
        ST_TRIGGERED,
        ST_ALIGNED
    } align_state_t;

    align_state_t    state;
    logic [LW-1:0]   prev_bits;
    logic [LW-1:0]   cur_bits;
    logic [2*LW-1:0] window;
    logic [LW-1:0]   comma_at;
    logic [LW-1:0]   frame;
    logic [OW-1:0]   offset;
    logic [OW-1:0]   twin;
    logic [OW-1:0]   found;
    logic [OW-1:0]   offset_next;
    logic            comma;
    logic            hit;
    logic            realign;

    // serial order, first bit received in the msb
    assign cur_bits = {line_rx.sym_lo, line_rx.sym_hi};
    assign window   = {prev_bits, cur_bits};

    always_comb begin
        comma_at = '0;
        for (int p = 0; p < LW; p++) begin
            comma_at[p] = (window[2*LW-1-p -: SYM] == `PCS_K28_5_RDN) ||
                          (window[2*LW-1-p -: SYM] == `PCS_K28_5_RDP);
        end
    end

    // lowest offset wins
    always_comb begin
        found = '0;
        for (int p = LW - 1; p >= 0; p--) begin
            if (comma_at[p]) begin
                found = OW'(p);
            end
        end
    end

    // a comma one symbol away still matches the current boundary
    assign twin = (offset >= OW'(SYM)) ? offset - OW'(SYM) : offset + OW'(SYM);

    assign comma       = |comma_at;
    assign hit         = comma_at[offset] | comma_at[twin];
    assign realign     = comma & ~hit;
    assign offset_next = realign ? found : offset;
    assign frame       = window[2*LW-1-offset_next -: LW];

    always_ff @(posedge txusrclk) begin
        prev_bits           <= cur_bits;
        aligned_word.sym_lo <= frame[LW-1 -: SYM];
        aligned_word.sym_hi <= frame[SYM-1:0];
    end

    always_ff @(posedge txusrclk) begin
        if (rst) begin
            offset     <= '0;
            rx_realign <= 1'b0;
            state      <= ST_NONALIGNED;
        end else begin
            offset     <= offset_next;
            rx_realign <= realign;
            if (realign) begin
                state <= ST_NONALIGNED;
            end else if (comma) begin
                // second comma on the same boundary confirms it
                case (state)
                    ST_NONALIGNED: state <= ST_TRIGGERED;
                    default:       state <= ST_ALIGNED;
                endcase
            end
        end
    end

    assign rx_aligned = (state == ST_ALIGNED);

endmodule

`default_nettype wire

/* source/dec_10b8b.sv */
// Two-symbol 10b/8b decoder
`default_nettype none
`timescale 1ns/100ps

module dec_10b8b
    import pcs_pkg::*;
(
    input  logic       txusrclk,
    input  logic       rst,
    input  line_word_t aligned_word,
    output rx_word_t   rx_word
);

    // running disparity, 0 is negative
    logic        rd;
    logic [11:0] lo_res;
    logic [11:0] hi_res;

    // result is {ending rd, disperr, notintable, k, data}
    function automatic logic [11:0] decode_symbol(
        input logic [9:0] sym,
        input logic       rd_in
    );
        logic [5:0] c6;
        logic [3:0] c4;
        logic [3:0] c4_eff;
        logic [4:0] x;
        logic [2:0] y;
        logic       bad6;
        logic       bad4;
        logic       k28;
        logic       alt;
        logic       k;
        logic       err6;
        logic       err4;
        logic       rd_mid;
        logic       rd_end;
        int         ones6;
        int         ones4;

        c6   = sym[9:4];
        c4   = sym[3:0];
        bad6 = 1'b0;
        k28  = 1'b0;
        case (c6)
            6'b100111, 6'b011000: x = 5'd0;
            6'b011101, 6'b100010: x = 5'd1;
            6'b101101, 6'b010010: x = 5'd2;
            6'b110001:            x = 5'd3;
            6'b110101, 6'b001010: x = 5'd4;
            6'b101001:            x = 5'd5;
            6'b011001:            x = 5'd6;
            6'b111000, 6'b000111: x = 5'd7;
            6'b111001, 6'b000110: x = 5'd8;
            6'b100101:            x = 5'd9;
            6'b010101:            x = 5'd10;
            6'b110100:            x = 5'd11;
            6'b001101:            x = 5'd12;
            6'b101100:            x = 5'd13;
            6'b011100:            x = 5'd14;
            6'b010111, 6'b101000: x = 5'd15;
            6'b011011, 6'b100100: x = 5'd16;
            6'b100011:            x = 5'd17;
            6'b010011:            x = 5'd18;
            6'b110010:            x = 5'd19;
            6'b001011:            x = 5'd20;
            6'b101010:            x = 5'd21;
            6'b011010:            x = 5'd22;
            6'b111010, 6'b000101: x = 5'd23;
            6'b110011, 6'b001100: x = 5'd24;
            6'b100110:            x = 5'd25;
            6'b010110:            x = 5'd26;
            6'b110110, 6'b001001: x = 5'd27;
            6'b001110:            x = 5'd28;
            6'b101110, 6'b010001: x = 5'd29;
            6'b011110, 6'b100001: x = 5'd30;
            6'b101011, 6'b010100: x = 5'd31;
            6'b001111, 6'b110000: begin
                x   = 5'd28;
                k28 = 1'b1;
            end
            default: begin
                x    = 5'd0;
                bad6 = 1'b1;
            end
        endcase

        // negative K28 prefix carries complemented balanced 4b codes
        c4_eff = (c6 == 6'b110000) ? ~c4 : c4;
        alt    = 1'b0;
        bad4   = 1'b0;
        case (c4_eff)
            4'b1011, 4'b0100: y = 3'd0;
            4'b1001:          y = 3'd1;
            4'b0101:          y = 3'd2;
            4'b1100, 4'b0011: y = 3'd3;
            4'b1101, 4'b0010: y = 3'd4;
            4'b1010:          y = 3'd5;
            4'b0110:          y = 3'd6;
            4'b1110, 4'b0001: y = 3'd7;
            4'b0111, 4'b1000: begin
                y   = 3'd7;
                alt = 1'b1;
            end
            default: begin
                y    = 3'd0;
                bad4 = 1'b1;
            end
        endcase
        if (alt && !k28 && !(x inside {5'd11, 5'd13, 5'd14, 5'd17, 5'd18,
                                       5'd20, 5'd23, 5'd27, 5'd29, 5'd30})) begin
            bad4 = 1'b1;
        end
        k = k28 || (alt && (x inside {5'd23, 5'd27, 5'd29, 5'd30}));

        ones6  = $countones(c6);
        ones4  = $countones(c4);
        err6   = (ones6 > 3 && rd_in) || (ones6 < 3 && !rd_in) ||
                 (c6 == 6'b111000 && rd_in) || (c6 == 6'b000111 && !rd_in);
        rd_mid = (ones6 == 3) ? rd_in : (ones6 > 3);
        err4   = (ones4 > 2 && rd_mid) || (ones4 < 2 && !rd_mid) ||
                 (c4 == 4'b1100 && rd_mid) || (c4 == 4'b0011 && !rd_mid);
        rd_end = (ones4 == 2) ? rd_mid : (ones4 > 2);

        return {rd_end, err6 | err4, bad6 | bad4, k, y, x};
    endfunction

    assign lo_res = decode_symbol(aligned_word.sym_lo, rd);
    assign hi_res = decode_symbol(aligned_word.sym_hi, lo_res[11]);

    always_ff @(posedge txusrclk) begin
        rx_word.data       <= {hi_res[7:0], lo_res[7:0]};
        rx_word.charisk    <= {hi_res[8], lo_res[8]};
        rx_word.notintable <= {hi_res[9], lo_res[9]};
        rx_word.disperr    <= {hi_res[10], lo_res[10]};
        if (rst) begin
            rd <= 1'b0;
        end else begin
            rd <= hi_res[11];
        end
    end

endmodule

`default_nettype wire

/* source/fabric_pcs.sv */
// Fabric PCS top level
`default_nettype none
`timescale 1ns/100ps

module fabric_pcs
    import pcs_pkg::*;
(
    input  logic       txusrclk,
    input  logic       rst,
    input  logic       tx_strobe,
    input  tx_dword_t  tx_dword,
    input  line_word_t line_rx,
    output line_word_t line_tx,
    output rx_word_t   rx_word,
    output logic       rx_aligned,
    output logic       rx_realign
);

    tx_word_t   enc_word;
    line_word_t aligned_word;

    // transmit chain
    tx_gearbox u_tx_gearbox (
        .txusrclk (txusrclk),
        .rst      (rst),
        .tx_strobe(tx_strobe),
        .tx_dword (tx_dword),
        .enc_word (enc_word)
    );

    enc_8b10b u_enc_8b10b (
        .txusrclk(txusrclk),
        .rst     (rst),
        .enc_word(enc_word),
        .line_tx (line_tx)
    );

    // receive chain
    comma_align u_comma_align (
        .txusrclk    (txusrclk),
        .rst         (rst),
        .line_rx     (line_rx),
        .aligned_word(aligned_word),
        .rx_aligned  (rx_aligned),
        .rx_realign  (rx_realign)
    );

    dec_10b8b u_dec_10b8b (
        .txusrclk    (txusrclk),
        .rst         (rst),
        .aligned_word(aligned_word),
        .rx_word     (rx_word)
    );

endmodule

`default_nettype wire

/* bench/fabric_pcs_tb.sv */
// Fabric PCS testbench
`default_nettype none
`timescale 1ns/100ps

`include "pcs_cfg.svh"

module fabric_pcs_tb
    import pcs_pkg::*;
();

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 10;
    localparam int          LINE_BITS    = 2 * `PCS_SYMBOL_BITS;
    localparam int          NUM_DWORDS   = 64;
    localparam int unsigned SEED         = 32'hff44_237f;
    localparam logic [9:0]  D21_5        = 10'b1010101010;
    localparam rx_word_t    IDLE_RX      = '{disperr: '0, notintable: '0,
                                             charisk: `PCS_IDLE_ISK,
                                             data: `PCS_IDLE_DATA};

    // the watchdog allows twice the summed cycle budget of the tests
    localparam int IDLE_CYCLES     = 10;
    localparam int ALIGN_CYCLES    = LINE_BITS * 30;
    localparam int ROUND_CYCLES    = 30 + 6 + 2 * NUM_DWORDS + 40 + 8;
    localparam int INJECT_CYCLES   = 2 * 24;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + IDLE_CYCLES + ALIGN_CYCLES +
                                          ROUND_CYCLES + INJECT_CYCLES);

    logic       txusrclk;
    logic       rst;
    logic       tx_strobe;
    tx_dword_t  tx_dword;
    line_word_t line_rx;
    line_word_t line_tx;
    rx_word_t   rx_word;
    logic       rx_aligned;
    logic       rx_realign;

    // loopback and monitor controls written by the main sequence on rising edges
    int         slip;
    logic       zero_req;
    logic       dup_req;
    logic       mon_on;
    logic       collect;
    rx_word_t   rx_q[$];
    rx_word_t   exp_q[$];

    fabric_pcs UUT (
        .txusrclk  (txusrclk),
        .rst       (rst),
        .tx_strobe (tx_strobe),
        .tx_dword  (tx_dword),
        .line_rx   (line_rx),
        .line_tx   (line_tx),
        .rx_word   (rx_word),
        .rx_aligned(rx_aligned),
        .rx_realign(rx_realign)
    );

    initial begin
        txusrclk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) txusrclk = ~txusrclk;
        end
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string reason);
        $display("%0d ns: %s", $time, reason);
        stop_run();
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_line(input string name, input line_word_t got, input line_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_rx_word(input string name, input rx_word_t got, input rx_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // random dword with K flags only on K28.5 bytes and no half equal to idle
    function automatic tx_dword_t make_dword();
        tx_dword_t d;
        for (int b = 0; b < `PCS_DWORD_BYTES; b++) begin
            d.data[b*8 +: 8] = 8'($urandom);
            d.charisk[b]     = 1'b0;
            if ($urandom_range(7) == 0) begin
                d.data[b*8 +: 8] = 8'hBC;
                d.charisk[b]     = 1'b1;
            end
        end
        for (int h = 0; h < 2; h++) begin
            if (d.data[h*16 +: 16] == `PCS_IDLE_DATA && d.charisk[h*2 +: 2] == `PCS_IDLE_ISK) begin
                d.charisk[h*2] = 1'b0;
            end
        end
        return d;
    endfunction

    // serial loopback delaying the stream by slip bits
    initial begin : loopback
        line_word_t  fb;
        logic [39:0] sr;
        logic [19:0] w;
        sr      = '0;
        line_rx = '0;
        forever begin
            @(negedge txusrclk);
            fb = line_tx;
            if (zero_req) begin
                fb.sym_hi = '0;
            end else if (dup_req && fb.sym_lo == `PCS_K28_5_RDN) begin
                fb.sym_hi = `PCS_K28_5_RDN;
            end
            sr             = {sr[19:0], fb.sym_lo, fb.sym_hi};
            w              = sr[19+slip -: 20];
            line_rx.sym_lo = w[19:10];
            line_rx.sym_hi = w[9:0];
        end
    end

    // every symbol has 4 to 6 ones and unbalanced ones alternate in sign
    initial begin : disparity_monitor
        int         last_sign;
        int         ones;
        logic [9:0] sym;
        last_sign = 0;
        forever begin
            @(negedge txusrclk);
            if (mon_on) begin
                for (int s = 0; s < 2; s++) begin
                    sym  = (s == 0) ? line_tx.sym_lo : line_tx.sym_hi;
                    ones = $countones(sym);
                    if (ones < 4 || ones > 6) begin
                        abort_run($sformatf("line_tx symbol %b has %0d ones", sym, ones));
                    end
                    if (ones != 5) begin
                        if (((ones > 5) ? 1 : -1) == last_sign) begin
                            abort_run($sformatf("line_tx symbol %b repeats disparity sign", sym));
                        end
                        last_sign = (ones > 5) ? 1 : -1;
                    end
                end
            end
        end
    end

    initial begin : rx_collector
        forever begin
            @(negedge txusrclk);
            if (collect) begin
                check_bit("rx_realign", rx_realign, 1'b0);
                if (rx_word !== IDLE_RX) begin
                    rx_q.push_back(rx_word);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    task automatic run_idle_after_reset();
        line_word_t exp_line;
        @(posedge txusrclk);
        mon_on          = 1'b1;
        exp_line.sym_hi = D21_5;
        for (int i = 0; i < 8; i++) begin
            @(negedge txusrclk);
            exp_line.sym_lo = (i % 2 == 0) ? `PCS_K28_5_RDN : `PCS_K28_5_RDP;
            check_line("line_tx", line_tx, exp_line);
        end
    endtask

    task automatic apply_slip(input int k);
        int   n;
        logic changed;
        changed = (k != slip);
        @(posedge txusrclk);
        slip = k;
        n    = 0;
        if (changed) begin
            do begin
                @(negedge txusrclk);
                n++;
            end while (rx_realign !== 1'b1 && n < 10);
            if (rx_realign !== 1'b1) begin
                abort_run($sformatf("no rx_realign pulse after slip moved to %0d", k));
            end
            check_bit("rx_aligned", rx_aligned, 1'b0);
            // one comma only reaches the triggered state
            @(negedge txusrclk);
            check_bit("rx_realign", rx_realign, 1'b0);
            check_bit("rx_aligned", rx_aligned, 1'b0);
        end else begin
            @(negedge txusrclk);
        end
        n = 0;
        while (rx_aligned !== 1'b1 && n < 10) begin
            @(negedge txusrclk);
            n++;
        end
        if (rx_aligned !== 1'b1) begin
            abort_run($sformatf("rx_aligned never rose with slip %0d", k));
        end
        repeat (6) begin
            @(negedge txusrclk);
            check_bit("rx_realign", rx_realign, 1'b0);
            check_bit("rx_aligned", rx_aligned, 1'b1);
        end
    endtask

    task automatic run_alignment();
        for (int k = 0; k < LINE_BITS; k++) begin
            apply_slip(k);
        end
    endtask

    task automatic run_round_trip();
        tx_dword_t dw;
        rx_word_t  exp_word;
        int        n;
        apply_slip(13);
        repeat (6) @(posedge txusrclk);
        collect = 1'b1;
        for (int i = 0; i < NUM_DWORDS; i++) begin
            dw               = make_dword();
            exp_word         = '0;
            exp_word.data    = dw.data[15:0];
            exp_word.charisk = dw.charisk[1:0];
            exp_q.push_back(exp_word);
            exp_word.data    = dw.data[31:16];
            exp_word.charisk = dw.charisk[3:2];
            exp_q.push_back(exp_word);
            @(negedge txusrclk);
            tx_strobe = 1'b1;
            tx_dword  = dw;
            @(negedge txusrclk);
            tx_strobe = 1'b0;
        end
        n = 0;
        while (rx_q.size() < exp_q.size() && n < 40) begin
            @(posedge txusrclk);
            n++;
        end
        repeat (8) @(posedge txusrclk);
        collect = 1'b0;
        if (rx_q.size() != exp_q.size()) begin
            abort_run($sformatf("received %0d words, sent %0d", rx_q.size(), exp_q.size()));
        end
        foreach (exp_q[i]) begin
            check_rx_word($sformatf("rx_word[%0d]", i), rx_q[i], exp_q[i]);
        end
    endtask

    task automatic run_invalid_symbol();
        int n;
        repeat (6) @(posedge txusrclk);
        zero_req = 1'b1;
        @(posedge txusrclk);
        zero_req = 1'b0;
        n        = 0;
        do begin
            @(negedge txusrclk);
            n++;
        end while (rx_word.notintable == 2'b00 && n < 12);
        if (rx_word.notintable == 2'b00) begin
            abort_run("no notintable flag after a zeroed symbol");
        end
        check_bit("rx_word.notintable[1]", rx_word.notintable[1], 1'b1);
        check_bit("rx_word.notintable[0]", rx_word.notintable[0], 1'b0);
    endtask

    task automatic run_disparity_error();
        int n;
        repeat (6) @(posedge txusrclk);
        // two edges so that exactly one word starts with K28.5 RD-
        dup_req = 1'b1;
        repeat (2) @(posedge txusrclk);
        dup_req = 1'b0;
        n       = 0;
        do begin
            @(negedge txusrclk);
            n++;
        end while (rx_word.disperr == 2'b00 && n < 12);
        if (rx_word.disperr == 2'b00) begin
            abort_run("no disperr flag after two K28.5 RD- symbols");
        end
        check_bit("rx_word.disperr[1]", rx_word.disperr[1], 1'b1);
        check_bit("rx_word.disperr[0]", rx_word.disperr[0], 1'b0);
        check_bit("rx_word.notintable[1]", rx_word.notintable[1], 1'b0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst       = 1'b1;
        tx_strobe = 1'b0;
        tx_dword  = '0;
        slip      = 0;
        zero_req  = 1'b0;
        dup_req   = 1'b0;
        mon_on    = 1'b0;
        collect   = 1'b0;
        repeat (RESET_CYCLES) @(negedge txusrclk);
        rst = 1'b0;
        run_idle_after_reset();
        run_alignment();
        run_round_trip();
        run_invalid_symbol();
        run_disparity_error();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
source/pcs_pkg.sv
source/tx_gearbox.sv
source/enc_8b10b.sv
source/comma_align.sv
source/dec_10b8b.sv
source/fabric_pcs.sv
bench/fabric_pcs_tb.sv

/* Makefile */
# Verilator flow for the fabric PCS testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fabric_pcs_tb
RTL_TOP   ?= fabric_pcs
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
